//--- Bender.yml
package:
  name: im2col_dma_agen

sources:
  - src/im2col_pkg.sv
  - src/job_fifo.sv
  - src/im2col_ctrl.sv
  - src/im2col_job_gen.sv
  - src/dma_channel_tracker.sv
  - src/dma_cfg_writer.sv
  - src/im2col_top.sv
  - target: test
    files:
      - verification/tb_im2col.sv

//--- all.f
src/im2col_pkg.sv
src/job_fifo.sv
src/im2col_ctrl.sv
src/im2col_job_gen.sv
src/dma_channel_tracker.sv
src/dma_cfg_writer.sv
src/im2col_top.sv
verification/tb_im2col.sv

//--- src/dma_cfg_writer.sv
// Programs one queued job into a claimed DMA channel, one four-phase bus write
// per register; the SIZE_D1 write goes last and launches the channel
`timescale 1ns/1ps
`default_nettype none

module dma_cfg_writer (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire                               fifo_empty_i,
  input  wire [im2col_pkg::JOB_W-1:0]       job_i,
  output logic                              pop_o,
  input  wire                               free_valid_i,
  input  wire [im2col_pkg::CH_IDX_W-1:0]    free_ch_i,
  input  wire                               first_use_i,
  output logic                              claim_o,
  output logic [im2col_pkg::CH_IDX_W-1:0]   claim_ch_o,
  output logic                              idle_o,
  input  wire [im2col_pkg::STRIDE_W-1:0]    stride_w_i,
  output logic                              bus_req_o,
  output logic [im2col_pkg::ADDR_W-1:0]     bus_addr_o,
  output logic [im2col_pkg::DATA_W-1:0]     bus_wdata_o,
  input  wire                               bus_ack_i
);

  logic                            busy_q, req_q;
  logic [3:0]                      step_q;
  logic [im2col_pkg::CH_IDX_W-1:0] ch_q;
  logic [im2col_pkg::ADDR_W-1:0]   offset;
  logic                            exch_done;  // Request dropped and ack back low

  assign claim_o    = !busy_q && !fifo_empty_i && free_valid_i;
  assign claim_ch_o = free_ch_i;
  assign idle_o     = !busy_q;
  assign bus_req_o  = req_q;
  assign exch_done  = busy_q && !req_q && !bus_ack_i;
  assign pop_o      = exch_done && (step_q == im2col_pkg::WR_SIZE_D1);
  assign bus_addr_o = im2col_pkg::DMA_BASE_ADDR + ch_q * im2col_pkg::DMA_CH_SIZE + offset;

  always_comb begin
    case (step_q)
      im2col_pkg::WR_DIM: begin
        offset      = im2col_pkg::DMA_DIMENSIONALITY_OFFSET;
        bus_wdata_o = 32'd1;  // 2-D transfers
      end
      im2col_pkg::WR_TOP_PAD: begin
        offset      = im2col_pkg::DMA_TOP_PAD_OFFSET;
        bus_wdata_o = 32'(job_i[im2col_pkg::JOB_ZT_LSB +: im2col_pkg::PAD_W])
                      * im2col_pkg::ELEM_BYTES;
      end
      im2col_pkg::WR_LEFT_PAD: begin
        offset      = im2col_pkg::DMA_LEFT_PAD_OFFSET;
        bus_wdata_o = 32'(job_i[im2col_pkg::JOB_ZL_LSB +: im2col_pkg::PAD_W])
                      * im2col_pkg::ELEM_BYTES;
      end
      im2col_pkg::WR_SRC: begin
        offset      = im2col_pkg::DMA_SRC_PTR_OFFSET;
        bus_wdata_o = job_i[im2col_pkg::JOB_SRC_LSB +: im2col_pkg::ADDR_W];
      end
      im2col_pkg::WR_DST: begin
        offset      = im2col_pkg::DMA_DST_PTR_OFFSET;
        bus_wdata_o = job_i[im2col_pkg::JOB_DST_LSB +: im2col_pkg::ADDR_W];
      end
      im2col_pkg::WR_INC_D1: begin
        offset      = im2col_pkg::DMA_INC_SRC_D1_OFFSET;
        bus_wdata_o = 32'(stride_w_i) * im2col_pkg::ELEM_BYTES;
      end
      im2col_pkg::WR_INC_D2: begin
        offset      = im2col_pkg::DMA_INC_SRC_D2_OFFSET;
        bus_wdata_o = job_i[im2col_pkg::JOB_INC_LSB +: im2col_pkg::DATA_W];
      end
      im2col_pkg::WR_SIZE_D2: begin
        offset      = im2col_pkg::DMA_SIZE_D2_OFFSET;
        bus_wdata_o = 32'(job_i[im2col_pkg::JOB_SD2_LSB +: im2col_pkg::DIM_W]);
      end
      default: begin  // SIZE_D1
        offset      = im2col_pkg::DMA_SIZE_D1_OFFSET;
        bus_wdata_o = 32'(job_i[im2col_pkg::JOB_SD1_LSB +: im2col_pkg::DIM_W]);
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      req_q  <= 1'b0;
      step_q <= im2col_pkg::WR_DIM;
      ch_q   <= '0;
    end else if (claim_o) begin
      busy_q <= 1'b1;
      req_q  <= 1'b1;
      step_q <= first_use_i ? im2col_pkg::WR_DIM : im2col_pkg::WR_TOP_PAD;
      ch_q   <= free_ch_i;
    end else if (req_q && bus_ack_i) begin
      req_q <= 1'b0;
    end else if (exch_done) begin
      if (step_q == im2col_pkg::WR_SIZE_D1) begin
        busy_q <= 1'b0;
      end else begin
        step_q <= step_q + 4'd1;
        req_q  <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/dma_channel_tracker.sv
// Busy and first-use bookkeeping per DMA channel, with lowest-free-channel search
`timescale 1ns/1ps
`default_nettype none

module dma_channel_tracker (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 run_start_i,
  input  wire [im2col_pkg::DMA_CH_NUM-1:0]    ch_mask_i,
  input  wire [im2col_pkg::DMA_CH_NUM-1:0]    dma_done_i,
  input  wire                                 claim_i,
  input  wire [im2col_pkg::CH_IDX_W-1:0]      claim_ch_i,
  output logic                                free_valid_o,
  output logic [im2col_pkg::CH_IDX_W-1:0]     free_ch_o,
  output logic                                first_use_o,
  output logic                                all_free_o
);

  logic [im2col_pkg::DMA_CH_NUM-1:0] busy_q, used_q, claim_oh;

  assign claim_oh    = {{(im2col_pkg::DMA_CH_NUM-1){1'b0}}, claim_i} << claim_ch_i;
  assign first_use_o = !used_q[free_ch_o];
  assign all_free_o  = ~|busy_q;

  // Scan from the top so the lowest idle channel wins
  always_comb begin
    free_valid_o = 1'b0;
    free_ch_o    = '0;
    for (int i = im2col_pkg::DMA_CH_NUM - 1; i >= 0; i--) begin
      if (ch_mask_i[i] && !busy_q[i]) begin
        free_valid_o = 1'b1;
        free_ch_o    = i[im2col_pkg::CH_IDX_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
      used_q <= '0;
    end else begin
      busy_q <= (busy_q & ~dma_done_i) | claim_oh;
      used_q <= run_start_i ? '0 : (used_q | claim_oh);  // DIM rewritten each run
    end
  end

endmodule

`default_nettype wire

//--- src/im2col_ctrl.sv
// Four-phase start handshake and run completion for the im2col generator
`timescale 1ns/1ps
`default_nettype none

module im2col_ctrl (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  start_req_i,
  output logic start_ack_o,
  input  wire  gen_done_i,
  input  wire  fifo_empty_i,
  input  wire  writer_idle_i,
  input  wire  all_free_i,
  output logic run_start_o
);

  logic [1:0] state_q, state_d;
  logic       run_done;

  // Every job generated, written and finished by its channel
  assign run_done = gen_done_i && fifo_empty_i && writer_idle_i && all_free_i;

  // Request seen in idle is always a rising edge, ACK waits for it to fall
  assign run_start_o = (state_q == im2col_pkg::CTRL_IDLE) && start_req_i;
  assign start_ack_o = (state_q == im2col_pkg::CTRL_ACK);

  always_comb begin
    state_d = state_q;
    case (state_q)
      im2col_pkg::CTRL_IDLE: if (start_req_i) state_d = im2col_pkg::CTRL_RUN;
      im2col_pkg::CTRL_RUN:  if (run_done) state_d = im2col_pkg::CTRL_ACK;
      im2col_pkg::CTRL_ACK:  if (!start_req_i) state_d = im2col_pkg::CTRL_IDLE;
      default:               state_d = im2col_pkg::CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= im2col_pkg::CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- src/im2col_job_gen.sv
// Walks channel, filter row and filter column and computes one DMA job per step
// Each job takes five cycles and waits in the push state while the queue is full
`timescale 1ns/1ps
`default_nettype none

module im2col_job_gen (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  wire                                run_start_i,
  input  wire [im2col_pkg::ADDR_W-1:0]       src_ptr_i,
  input  wire [im2col_pkg::ADDR_W-1:0]       dst_ptr_i,
  input  wire [im2col_pkg::DIM_W-1:0]        ih_i,
  input  wire [im2col_pkg::DIM_W-1:0]        iw_i,
  input  wire [im2col_pkg::DIM_W-1:0]        fh_i,
  input  wire [im2col_pkg::DIM_W-1:0]        fw_i,
  input  wire [im2col_pkg::DIM_W-1:0]        num_ch_i,
  input  wire [im2col_pkg::DIM_W-1:0]        n_patches_h_i,
  input  wire [im2col_pkg::DIM_W-1:0]        n_patches_w_i,
  input  wire [im2col_pkg::STRIDE_W-1:0]     stride_w_i,
  input  wire [im2col_pkg::STRIDE_W-1:0]     stride_h_i,
  input  wire [im2col_pkg::PAD_W-1:0]        pad_top_i,
  input  wire [im2col_pkg::PAD_W-1:0]        pad_left_i,
  input  wire                                fifo_full_i,
  output logic                               push_o,
  output logic [im2col_pkg::JOB_W-1:0]       job_o,
  output logic                               gen_done_o
);

  logic [2:0]                       state_q, state_d;
  logic [im2col_pkg::DIM_W-1:0]     ch_q, h_off_q, w_off_q;
  logic                             last_job;
  logic [31:0]                      row_base_q, col_base_q;  // Offset minus padding, may wrap
  logic [im2col_pkg::PAD_W-1:0]     zt_q, zl_q;
  logic [im2col_pkg::DIM_W-1:0]     sd1_d, sd2_d, sd1_q, sd2_q;
  logic [31:0]                      index_d, inc_d, inc_q;
  logic [im2col_pkg::ADDR_W-1:0]    src_q, dst_q;

  // Ceiling of the padding still ahead of the window, in strides
  function automatic logic [im2col_pkg::PAD_W-1:0] zero_count(
    input logic [31:0]                   base,
    input logic [im2col_pkg::STRIDE_W-1:0] stride
  );
    logic [31:0] gap;
    logic [31:0] quot;
    gap  = 32'd0 - base + 32'(stride) - 32'd1;
    quot = gap / 32'(stride);
    return base[31] ? quot[im2col_pkg::PAD_W-1:0] : '0;
  endfunction

  assign sd1_d   = n_patches_w_i - zl_q;
  assign sd2_d   = n_patches_h_i - zt_q;
  assign index_d = (32'(ch_q) * 32'(ih_i) + row_base_q + 32'(zt_q) * 32'(stride_h_i))
                   * 32'(iw_i) + col_base_q + 32'(zl_q) * 32'(stride_w_i);
  assign inc_d   = (32'(stride_h_i) * 32'(iw_i) - (32'(sd1_d) - 32'd1) * 32'(stride_w_i))
                   * im2col_pkg::ELEM_BYTES;

  assign last_job = (w_off_q == fw_i - 1'b1) && (h_off_q == fh_i - 1'b1)
                    && (ch_q == num_ch_i - 1'b1);
  assign push_o   = (state_q == im2col_pkg::GEN_PUSH) && !fifo_full_i;
  assign job_o    = {src_q, dst_q, inc_q, sd1_q, sd2_q, zt_q, zl_q};

  always_comb begin
    state_d = state_q;
    case (state_q)
      im2col_pkg::GEN_IDLE:      if (run_start_i) state_d = im2col_pkg::GEN_OFFSETS;
      im2col_pkg::GEN_OFFSETS:   state_d = im2col_pkg::GEN_ZEROS;
      im2col_pkg::GEN_ZEROS:     state_d = im2col_pkg::GEN_RUN_PARAM;
      im2col_pkg::GEN_RUN_PARAM: state_d = im2col_pkg::GEN_PUSH;
      im2col_pkg::GEN_PUSH:      if (!fifo_full_i) state_d = im2col_pkg::GEN_UPDATE;
      im2col_pkg::GEN_UPDATE: begin
        state_d = last_job ? im2col_pkg::GEN_IDLE : im2col_pkg::GEN_OFFSETS;
      end
      default: state_d = im2col_pkg::GEN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= im2col_pkg::GEN_IDLE;
      ch_q       <= '0;
      h_off_q    <= '0;
      w_off_q    <= '0;
      gen_done_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (run_start_i) begin
        ch_q       <= '0;
        h_off_q    <= '0;
        w_off_q    <= '0;
        gen_done_o <= 1'b0;
      end else if (state_q == im2col_pkg::GEN_UPDATE) begin
        gen_done_o <= last_job;
        if (w_off_q == fw_i - 1'b1) begin  // Column wraps into next row, then channel
          w_off_q <= '0;
          if (h_off_q == fh_i - 1'b1) begin
            h_off_q <= '0;
            ch_q    <= ch_q + 1'b1;
          end else begin
            h_off_q <= h_off_q + 1'b1;
          end
        end else begin
          w_off_q <= w_off_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (run_start_i) begin
      dst_q <= dst_ptr_i;
    end
    case (state_q)
      im2col_pkg::GEN_OFFSETS: begin
        row_base_q <= 32'(h_off_q) - 32'(pad_top_i);
        col_base_q <= 32'(w_off_q) - 32'(pad_left_i);
      end
      im2col_pkg::GEN_ZEROS: begin
        zt_q <= zero_count(row_base_q, stride_h_i);
        zl_q <= zero_count(col_base_q, stride_w_i);
      end
      im2col_pkg::GEN_RUN_PARAM: begin
        sd1_q <= sd1_d;
        sd2_q <= sd2_d;
        inc_q <= inc_d;
        src_q <= src_ptr_i + index_d * im2col_pkg::ELEM_BYTES;
      end
      im2col_pkg::GEN_UPDATE: begin  // One output patch plane per job
        dst_q <= dst_q + 32'(n_patches_h_i) * 32'(n_patches_w_i) * im2col_pkg::ELEM_BYTES;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/im2col_pkg.sv
// Shared widths, DMA register map, job word layout and FSM encodings
// for the im2col DMA address generator; referenced by package scope
`default_nettype none

package im2col_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int DIM_W      = 16;
  localparam int PAD_W      = 6;
  localparam int STRIDE_W   = 4;
  localparam int ELEM_BYTES = 4;   // 32-bit elements only

  localparam int DMA_CH_NUM = 2;
  localparam int CH_IDX_W   = (DMA_CH_NUM > 1) ? $clog2(DMA_CH_NUM) : 1;
  localparam logic [ADDR_W-1:0] DMA_BASE_ADDR = 32'h0003_0000;
  localparam logic [ADDR_W-1:0] DMA_CH_SIZE   = 32'h0000_0100;

  localparam logic [ADDR_W-1:0] DMA_SRC_PTR_OFFSET        = 32'h00;
  localparam logic [ADDR_W-1:0] DMA_DST_PTR_OFFSET        = 32'h04;
  localparam logic [ADDR_W-1:0] DMA_SIZE_D1_OFFSET        = 32'h0C;  // Write launches the channel
  localparam logic [ADDR_W-1:0] DMA_SIZE_D2_OFFSET        = 32'h10;
  localparam logic [ADDR_W-1:0] DMA_INC_SRC_D1_OFFSET     = 32'h18;
  localparam logic [ADDR_W-1:0] DMA_INC_SRC_D2_OFFSET     = 32'h1C;
  localparam logic [ADDR_W-1:0] DMA_DIMENSIONALITY_OFFSET = 32'h34;
  localparam logic [ADDR_W-1:0] DMA_TOP_PAD_OFFSET        = 32'h3C;
  localparam logic [ADDR_W-1:0] DMA_LEFT_PAD_OFFSET       = 32'h48;

  // Job word, LSB first: n_zeros_left, n_zeros_top, size_d2, size_d1, inc_src_d2, dst, src
  localparam int JOB_ZL_LSB  = 0;
  localparam int JOB_ZT_LSB  = PAD_W;
  localparam int JOB_SD2_LSB = 2 * PAD_W;
  localparam int JOB_SD1_LSB = JOB_SD2_LSB + DIM_W;
  localparam int JOB_INC_LSB = JOB_SD1_LSB + DIM_W;
  localparam int JOB_DST_LSB = JOB_INC_LSB + DATA_W;
  localparam int JOB_SRC_LSB = JOB_DST_LSB + ADDR_W;
  localparam int JOB_W       = JOB_SRC_LSB + ADDR_W;

  localparam int FIFO_DEPTH = 4;

  localparam logic [1:0] CTRL_IDLE = 2'd0;
  localparam logic [1:0] CTRL_RUN  = 2'd1;
  localparam logic [1:0] CTRL_ACK  = 2'd2;

  localparam logic [2:0] GEN_IDLE      = 3'd0;
  localparam logic [2:0] GEN_OFFSETS   = 3'd1;
  localparam logic [2:0] GEN_ZEROS     = 3'd2;
  localparam logic [2:0] GEN_RUN_PARAM = 3'd3;
  localparam logic [2:0] GEN_PUSH      = 3'd4;
  localparam logic [2:0] GEN_UPDATE    = 3'd5;

  // Writer steps, in bus order; the writer advances by incrementing
  localparam logic [3:0] WR_DIM      = 4'd0;
  localparam logic [3:0] WR_TOP_PAD  = 4'd1;
  localparam logic [3:0] WR_LEFT_PAD = 4'd2;
  localparam logic [3:0] WR_SRC      = 4'd3;
  localparam logic [3:0] WR_DST      = 4'd4;
  localparam logic [3:0] WR_INC_D1   = 4'd5;
  localparam logic [3:0] WR_INC_D2   = 4'd6;
  localparam logic [3:0] WR_SIZE_D2  = 4'd7;
  localparam logic [3:0] WR_SIZE_D1  = 4'd8;

endpackage

`default_nettype wire

//--- src/im2col_top.sv
// Top level of the im2col DMA address generator; the configuration ports
// must stay stable while the start request is high
`timescale 1ns/1ps
`default_nettype none

module im2col_top (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  wire                                start_req_i,
  output logic                               start_ack_o,
  input  wire [im2col_pkg::ADDR_W-1:0]       src_ptr_i,
  input  wire [im2col_pkg::ADDR_W-1:0]       dst_ptr_i,
  input  wire [im2col_pkg::DIM_W-1:0]        ih_i,
  input  wire [im2col_pkg::DIM_W-1:0]        iw_i,
  input  wire [im2col_pkg::DIM_W-1:0]        fh_i,
  input  wire [im2col_pkg::DIM_W-1:0]        fw_i,
  input  wire [im2col_pkg::DIM_W-1:0]        num_ch_i,
  input  wire [im2col_pkg::DIM_W-1:0]        n_patches_h_i,
  input  wire [im2col_pkg::DIM_W-1:0]        n_patches_w_i,
  input  wire [im2col_pkg::STRIDE_W-1:0]     stride_w_i,
  input  wire [im2col_pkg::STRIDE_W-1:0]     stride_h_i,
  input  wire [im2col_pkg::PAD_W-1:0]        pad_top_i,
  input  wire [im2col_pkg::PAD_W-1:0]        pad_left_i,
  input  wire [im2col_pkg::DMA_CH_NUM-1:0]   ch_mask_i,
  output logic                               bus_req_o,
  output logic [im2col_pkg::ADDR_W-1:0]      bus_addr_o,
  output logic [im2col_pkg::DATA_W-1:0]      bus_wdata_o,
  input  wire                                bus_ack_i,
  input  wire [im2col_pkg::DMA_CH_NUM-1:0]   dma_done_i
);

  logic                            run_start, gen_done, writer_idle, all_free;
  logic                            fifo_push, fifo_pop, fifo_full, fifo_empty;
  logic [im2col_pkg::JOB_W-1:0]    job_in, job_out;
  logic                            free_valid, first_use, claim;
  logic [im2col_pkg::CH_IDX_W-1:0] free_ch, claim_ch;

  im2col_ctrl u_ctrl (
    .clk_i, .rst_ni, .start_req_i, .start_ack_o,
    .gen_done_i    (gen_done),
    .fifo_empty_i  (fifo_empty),
    .writer_idle_i (writer_idle),
    .all_free_i    (all_free),
    .run_start_o   (run_start)
  );

  im2col_job_gen u_job_gen (
    .clk_i, .rst_ni,
    .run_start_i (run_start),
    .src_ptr_i, .dst_ptr_i, .ih_i, .iw_i, .fh_i, .fw_i, .num_ch_i,
    .n_patches_h_i, .n_patches_w_i, .stride_w_i, .stride_h_i, .pad_top_i, .pad_left_i,
    .fifo_full_i (fifo_full),
    .push_o      (fifo_push),
    .job_o       (job_in),
    .gen_done_o  (gen_done)
  );

  job_fifo #(
    .DEPTH (im2col_pkg::FIFO_DEPTH)
  ) u_job_fifo (
    .clk_i, .rst_ni,
    .push_i  (fifo_push),
    .data_i  (job_in),
    .pop_i   (fifo_pop),
    .data_o  (job_out),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  dma_channel_tracker u_tracker (
    .clk_i, .rst_ni, .ch_mask_i, .dma_done_i,
    .run_start_i  (run_start),
    .claim_i      (claim),
    .claim_ch_i   (claim_ch),
    .free_valid_o (free_valid),
    .free_ch_o    (free_ch),
    .first_use_o  (first_use),
    .all_free_o   (all_free)
  );

  dma_cfg_writer u_writer (
    .clk_i, .rst_ni, .stride_w_i, .bus_req_o, .bus_addr_o, .bus_wdata_o, .bus_ack_i,
    .fifo_empty_i (fifo_empty),
    .job_i        (job_out),
    .pop_o        (fifo_pop),
    .free_valid_i (free_valid),
    .free_ch_i    (free_ch),
    .first_use_i  (first_use),
    .claim_o      (claim),
    .claim_ch_o   (claim_ch),
    .idle_o       (writer_idle)
  );

endmodule

`default_nettype wire

//--- src/job_fifo.sv
// Fall-through queue of job words between generator and DMA writer
`timescale 1ns/1ps
`default_nettype none

module job_fifo #(
  parameter int DEPTH = 4
) (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          push_i,
  input  wire [im2col_pkg::JOB_W-1:0]  data_i,
  input  wire                          pop_i,
  output logic [im2col_pkg::JOB_W-1:0] data_o,
  output logic                         full_o,
  output logic                         empty_o
);

  logic [im2col_pkg::JOB_W-1:0] mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wptr_q, rptr_q;
  logic [$clog2(DEPTH+1)-1:0]   cnt_q;
  logic                         do_push, do_pop;

  assign full_o  = (cnt_q == DEPTH);
  assign empty_o = (cnt_q == 0);
  assign data_o  = mem[rptr_q];  // Head visible without a read cycle
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == DEPTH - 1) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == DEPTH - 1) ? '0 : rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + do_push - do_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_im2col.sv
// Testbench for the im2col DMA address generator. Runs three layer setups, answers
// the config bus and DMA done lines, and checks every write against a loop model
`timescale 1ns/1ps
`default_nettype none

module tb_im2col;

  localparam int CH_NUM      = im2col_pkg::DMA_CH_NUM;
  localparam int TOTAL_JOBS  = 1 * 3 * 3 + 2 * 3 * 3 + 1 * 2 * 2;
  localparam int CYCLE_LIMIT = TOTAL_JOBS * 200 + 1000;

  logic                            clk_i, rst_ni;
  logic                            start_req_i, start_ack_o;
  logic [im2col_pkg::ADDR_W-1:0]   src_ptr_i, dst_ptr_i;
  logic [im2col_pkg::DIM_W-1:0]    ih_i, iw_i, fh_i, fw_i, num_ch_i;
  logic [im2col_pkg::DIM_W-1:0]    n_patches_h_i, n_patches_w_i;
  logic [im2col_pkg::STRIDE_W-1:0] stride_w_i, stride_h_i;
  logic [im2col_pkg::PAD_W-1:0]    pad_top_i, pad_left_i;
  logic [CH_NUM-1:0]               ch_mask_i, dma_done_i;
  logic                            bus_req_o, bus_ack_i;
  logic [im2col_pkg::ADDR_W-1:0]   bus_addr_o;
  logic [im2col_pkg::DATA_W-1:0]   bus_wdata_o;

  int                cfg_ih, cfg_iw, cfg_fh, cfg_fw, cfg_pt, cfg_pl, cfg_sh, cfg_sw;
  int                cfg_nph, cfg_npw;
  int                mon_c, mon_h, mon_w, job_num, exp_jobs, size_cnt, done_cnt;
  logic              job_open;   // Between first write and SIZE_D1 of a job
  logic [3:0]        step;
  int                job_ch;
  logic [CH_NUM-1:0] ch_busy, ch_used;
  int                done_delay [CH_NUM];
  int                exp_zt, exp_zl, exp_sd1, exp_sd2;
  logic [31:0]       exp_src, exp_dst, exp_inc2;
  int                errors, tests_passed, tests_failed, cycles, ack_wait;
  logic [31:0]       rng;

  im2col_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic string step_name(input logic [3:0] s);
    case (s)
      im2col_pkg::WR_DIM:      return "DIM";
      im2col_pkg::WR_TOP_PAD:  return "TOP_PAD";
      im2col_pkg::WR_LEFT_PAD: return "LEFT_PAD";
      im2col_pkg::WR_SRC:      return "SRC";
      im2col_pkg::WR_DST:      return "DST";
      im2col_pkg::WR_INC_D1:   return "INC_D1";
      im2col_pkg::WR_INC_D2:   return "INC_D2";
      im2col_pkg::WR_SIZE_D2:  return "SIZE_D2";
      im2col_pkg::WR_SIZE_D1:  return "SIZE_D1";
      default:                 return "UNKNOWN";
    endcase
  endfunction

  function automatic logic [31:0] step_offset(input logic [3:0] s);
    case (s)
      im2col_pkg::WR_DIM:      return im2col_pkg::DMA_DIMENSIONALITY_OFFSET;
      im2col_pkg::WR_TOP_PAD:  return im2col_pkg::DMA_TOP_PAD_OFFSET;
      im2col_pkg::WR_LEFT_PAD: return im2col_pkg::DMA_LEFT_PAD_OFFSET;
      im2col_pkg::WR_SRC:      return im2col_pkg::DMA_SRC_PTR_OFFSET;
      im2col_pkg::WR_DST:      return im2col_pkg::DMA_DST_PTR_OFFSET;
      im2col_pkg::WR_INC_D1:   return im2col_pkg::DMA_INC_SRC_D1_OFFSET;
      im2col_pkg::WR_INC_D2:   return im2col_pkg::DMA_INC_SRC_D2_OFFSET;
      im2col_pkg::WR_SIZE_D2:  return im2col_pkg::DMA_SIZE_D2_OFFSET;
      default:                 return im2col_pkg::DMA_SIZE_D1_OFFSET;
    endcase
  endfunction

  function automatic logic [31:0] expected_data(input logic [3:0] s);
    case (s)
      im2col_pkg::WR_DIM:      return 32'd1;
      im2col_pkg::WR_TOP_PAD:  return 32'(exp_zt * 4);
      im2col_pkg::WR_LEFT_PAD: return 32'(exp_zl * 4);
      im2col_pkg::WR_SRC:      return exp_src;
      im2col_pkg::WR_DST:      return exp_dst;
      im2col_pkg::WR_INC_D1:   return 32'(cfg_sw * 4);
      im2col_pkg::WR_INC_D2:   return exp_inc2;
      im2col_pkg::WR_SIZE_D2:  return 32'(exp_sd2);
      default:                 return 32'(exp_sd1);
    endcase
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("** Error at %0d ns: %s", $time, msg);
  endtask

  // Expected job fields for the current channel, row and column offset
  task automatic model_job();
    int row;
    int col;
    exp_zl   = (mon_w >= cfg_pl) ? 0 : (cfg_pl - mon_w + cfg_sw - 1) / cfg_sw;
    exp_zt   = (mon_h >= cfg_pt) ? 0 : (cfg_pt - mon_h + cfg_sh - 1) / cfg_sh;
    row      = mon_h - cfg_pt + exp_zt * cfg_sh;
    col      = mon_w - cfg_pl + exp_zl * cfg_sw;
    exp_sd1  = cfg_npw - exp_zl;
    exp_sd2  = cfg_nph - exp_zt;
    exp_src  = src_ptr_i + 32'(4 * ((mon_c * cfg_ih + row) * cfg_iw + col));
    exp_dst  = dst_ptr_i + 32'(job_num * cfg_nph * cfg_npw * 4);
    exp_inc2 = 32'(4 * (cfg_sh * cfg_iw - (exp_sd1 - 1) * cfg_sw));
  endtask

  task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rel;
    int          ch;
    rel = addr - im2col_pkg::DMA_BASE_ADDR;
    ch  = int'(rel / im2col_pkg::DMA_CH_SIZE);
    if (rel >= CH_NUM * im2col_pkg::DMA_CH_SIZE) begin
      report_error($sformatf("write to 0x%08h outside the DMA channels", addr));
    end else begin
      if (!job_open) begin  // First write fixes the job's channel
        job_open = 1'b1;
        job_ch   = ch;
        step     = ch_used[ch] ? im2col_pkg::WR_TOP_PAD : im2col_pkg::WR_DIM;
        model_job();
      end
      assert (ch_mask_i[ch])
        else report_error($sformatf("write to channel %0d, not in the mask", ch));
      assert (ch == job_ch)
        else report_error($sformatf("job %0d moved from channel %0d to %0d",
                                    job_num, job_ch, ch));
      assert (!ch_busy[ch])
        else report_error($sformatf("write to channel %0d before its done pulse", ch));
      assert ((rel % im2col_pkg::DMA_CH_SIZE) == step_offset(step))
        else report_error($sformatf("job %0d: offset 0x%02h, expected %s",
                                    job_num, rel % im2col_pkg::DMA_CH_SIZE, step_name(step)));
      assert (data == expected_data(step))
        else report_error($sformatf("job %0d %s: data 0x%08h, expected 0x%08h",
                                    job_num, step_name(step), data, expected_data(step)));
      if (step == im2col_pkg::WR_SIZE_D1) begin  // Channel launched
        ch_busy[job_ch]    = 1'b1;
        ch_used[job_ch]    = 1'b1;
        rng                = xorshift32(rng);
        done_delay[job_ch] = 5 + int'(rng % 16);
        size_cnt++;
        job_num++;
        job_open = 1'b0;
        if (mon_w == cfg_fw - 1) begin
          mon_w = 0;
          if (mon_h == cfg_fh - 1) begin
            mon_h = 0;
            mon_c++;
          end else begin
            mon_h++;
          end
        end else begin
          mon_w++;
        end
      end else begin
        step = step + 4'd1;
      end
    end
  endtask

  // Writes are taken mid-cycle, where request and acknowledge overlap once
  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int i = 0; i < CH_NUM; i++) begin
        if (dma_done_i[i]) begin
          ch_busy[i] = 1'b0;
          done_cnt++;
        end
      end
      if (bus_req_o && bus_ack_i) begin
        check_write(bus_addr_o, bus_wdata_o);
      end
    end
  end

  // Bus responder and DMA done model
  always begin
    @(posedge clk_i);
    #2;
    if (!rst_ni) begin
      bus_ack_i  = 1'b0;
      dma_done_i = '0;
    end else begin
      if (bus_req_o && !bus_ack_i) begin
        if (ack_wait < 0) begin
          rng      = xorshift32(rng);
          ack_wait = int'(rng % 4);
        end
        if (ack_wait == 0) begin
          bus_ack_i = 1'b1;
        end
        ack_wait--;
      end else if (!bus_req_o && bus_ack_i) begin
        bus_ack_i = 1'b0;
      end
      dma_done_i = '0;
      for (int i = 0; i < CH_NUM; i++) begin
        if (done_delay[i] > 0) begin
          done_delay[i]--;
          if (done_delay[i] == 0) dma_done_i[i] = 1'b1;
        end
      end
    end
  end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && !bus_ack_i |=> bus_req_o)
    else report_error("bus_req_o dropped before bus_ack_i");
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && $past(bus_req_o) |-> $stable(bus_addr_o) && $stable(bus_wdata_o))
    else report_error("bus_addr_o or bus_wdata_o changed during a request");
  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(bus_req_o) |-> !$past(bus_ack_i))
    else report_error("bus_req_o rose while bus_ack_i was high");
  a_req_in_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o |-> start_req_i)
    else report_error("bus request outside a started run");
  a_ack_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_ack_o && start_req_i |=> start_ack_o)
    else report_error("start_ack_o fell while start_req_i was high");
  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(start_ack_o) |-> $past(!start_req_i))
    else report_error("start_ack_o fell before start_req_i dropped");
  a_ack_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(start_ack_o) |-> size_cnt == exp_jobs && done_cnt == exp_jobs && ch_busy == '0)
    else report_error($sformatf("start_ack_o after %0d launches and %0d done pulses",
                                size_cnt, done_cnt));

  task automatic run_test(input string name, input logic [31:0] src, input logic [31:0] dst,
                          input int nch, input int ih, input int iw, input int fh,
                          input int fw, input int pt, input int pl, input int sh,
                          input int sw, input logic [CH_NUM-1:0] mask);
    int errors_before;
    errors_before = errors;
    @(posedge clk_i);
    #2;
    cfg_ih  = ih;
    cfg_iw  = iw;
    cfg_fh  = fh;
    cfg_fw  = fw;
    cfg_pt  = pt;
    cfg_pl  = pl;
    cfg_sh  = sh;
    cfg_sw  = sw;
    cfg_nph = (ih + pt - fh) / sh + 1;  // No bottom or right padding
    cfg_npw = (iw + pl - fw) / sw + 1;
    src_ptr_i     = src;
    dst_ptr_i     = dst;
    num_ch_i      = 16'(nch);
    ih_i          = 16'(ih);
    iw_i          = 16'(iw);
    fh_i          = 16'(fh);
    fw_i          = 16'(fw);
    pad_top_i     = 6'(pt);
    pad_left_i    = 6'(pl);
    stride_h_i    = 4'(sh);
    stride_w_i    = 4'(sw);
    n_patches_h_i = 16'(cfg_nph);
    n_patches_w_i = 16'(cfg_npw);
    ch_mask_i     = mask;
    mon_c    = 0;
    mon_h    = 0;
    mon_w    = 0;
    job_num  = 0;
    size_cnt = 0;
    done_cnt = 0;
    exp_jobs = nch * fh * fw;
    job_open = 1'b0;
    ch_used  = '0;
    start_req_i = 1'b1;
    wait (start_ack_o);
    @(posedge clk_i);
    #2;
    start_req_i = 1'b0;
    wait (!start_ack_o);
    assert (job_num == exp_jobs && !job_open)
      else report_error($sformatf("%0d jobs written, expected %0d", job_num, exp_jobs));
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s passed, %0d jobs", name, exp_jobs);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run never completed", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rng          = 32'h8e610cd3;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    ack_wait     = -1;
    ch_busy      = '0;
    ch_used      = '0;
    job_open     = 1'b0;
    step         = im2col_pkg::WR_DIM;
    exp_jobs     = 0;
    size_cnt     = 0;
    done_cnt     = 0;
    for (int i = 0; i < CH_NUM; i++) done_delay[i] = 0;
    rst_ni        = 1'b0;
    start_req_i   = 1'b0;
    src_ptr_i     = '0;
    dst_ptr_i     = '0;
    ih_i          = '0;
    iw_i          = '0;
    fh_i          = '0;
    fw_i          = '0;
    num_ch_i      = '0;
    n_patches_h_i = '0;
    n_patches_w_i = '0;
    stride_w_i    = '0;
    stride_h_i    = '0;
    pad_top_i     = '0;
    pad_left_i    = '0;
    ch_mask_i     = '0;
    bus_ack_i     = 1'b0;
    dma_done_i    = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!bus_req_o && !start_ack_o)
      else report_error("bus_req_o or start_ack_o high after reset");
    repeat (3) @(posedge clk_i);
    run_test("one_channel_3x3_pad1_stride1", 32'h1000_0000, 32'h2000_0000,
             1, 5, 5, 3, 3, 1, 1, 1, 1, 2'b11);
    run_test("two_channel_3x3_stride2", 32'h1100_0040, 32'h2100_0000,
             2, 7, 7, 3, 3, 1, 1, 2, 2, 2'b11);
    run_test("mask_channel1_only", 32'h1200_0000, 32'h2200_0100,
             1, 6, 6, 2, 2, 1, 0, 2, 1, 2'b10);
    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
